//--- logic/decode_settings.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sized for the 16-bit, 8-register ISA only
// the opcode field must stay 5 bits wide to match isaPkg::opcode_e
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

`define INST_WIDTH      16      // one instruction word
`define PC_WIDTH        16      // byte address, word aligned
`define REG_IDX_WIDTH   3       // r0 to r7
`define LINK_REG        3'd7    // written by jal and jalr

`define OPC_MSB         15      // top of opcode field
`define OPC_LSB         11      // bottom of opcode field

`endif

//--- logic/isaPkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// encodings follow the teaching ISA opcode map, nothing else decoded
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "decode_settings.svh"

package isaPkg;

        typedef enum logic [`OPC_MSB-`OPC_LSB:0] {
                HALT     = 5'b00000,
                NOP      = 5'b00001,
                SIIC     = 5'b00010,
                RTI      = 5'b00011,    // acts as nop here
                J        = 5'b00100,
                JR       = 5'b00101,
                JAL      = 5'b00110,
                JALR     = 5'b00111,
                ADDI     = 5'b01000,
                SUBI     = 5'b01001,
                XORI     = 5'b01010,
                ANDNI    = 5'b01011,
                BEQZ     = 5'b01100,
                BNEZ     = 5'b01101,
                BLTZ     = 5'b01110,
                BGEZ     = 5'b01111,
                ST       = 5'b10000,
                LD       = 5'b10001,
                SLBI     = 5'b10010,
                STU      = 5'b10011,
                ROLI     = 5'b10100,
                SLLI     = 5'b10101,
                RORI     = 5'b10110,
                SRLI     = 5'b10111,
                LBI      = 5'b11000,
                BTR      = 5'b11001,
                ROL_SRL  = 5'b11010,    // func in bits 1:0
                ADD_ANDN = 5'b11011,    // func in bits 1:0
                SEQ      = 5'b11100,
                SLT      = 5'b11101,
                SLE      = 5'b11110,
                SCO      = 5'b11111
        } opcode_e;

        typedef enum logic [1:0] {
                REG_DST_I1   = 2'b00,   // bits 7:5
                REG_DST_R    = 2'b01,   // bits 4:2
                REG_DST_I2   = 2'b10,   // bits 10:8
                REG_DST_LINK = 2'b11    // fixed r7
        } regDst_e;

        typedef enum logic [1:0] {
                IMM_5  = 2'b00,
                IMM_8  = 2'b01,
                IMM_11 = 2'b10          // jump displacement
        } immSize_e;

        typedef logic [1:0] aluFunc_t;  // r-format sub-op

        typedef struct packed {
                opcode_e                   aluOp;
                aluFunc_t                  aluFunc;
                regDst_e                   regDst;
                logic                      jump;
                logic                      branch;
                logic                      memRead;
                logic                      memWrite;
                logic                      memToReg;
                logic                      aluSrc;
                logic                      regWrite;
                logic                      zeroEx;
                logic                      halt;
                logic                      dump;
                logic                      illegalOp;
                logic [`REG_IDX_WIDTH-1:0] writeReg;
                logic [`INST_WIDTH-1:0]    immediate;
                logic [`PC_WIDTH-1:0]      pc;
        } ctrlBundle_t;

endpackage

//--- logic/instFetch.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// no back-pressure, a strobe is taken or dropped in its own cycle
// once halted only reset restarts fetch
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "decode_settings.svh"

module instFetch (
        input  logic                   clk,
        input  logic                   rstN,
        input  logic                   instValid,
        input  logic [`INST_WIDTH-1:0] inst,
        input  logic                   haltDecoded,
        output logic                   fetchValid,
        output logic [`INST_WIDTH-1:0] fetchInst,
        output logic [`PC_WIDTH-1:0]   fetchPc
);
        localparam logic [`PC_WIDTH-1:0] pcStep = 2;    // one 16-bit word

        logic                 halted;                   // sticky until reset
        logic [`PC_WIDTH-1:0] pc;
        logic                 accept;

        // halt sitting in if/id already blocks this cycle's strobe
        assign accept     = instValid && !halted && !haltDecoded;
        assign fetchValid = accept;
        assign fetchInst  = inst;
        assign fetchPc    = pc;                         // pc of this word

        always_ff @(posedge clk) begin
                if (!rstN) begin
                        pc     <= '0;
                        halted <= 1'b0;
                end else begin
                        if (accept)
                                pc <= pc + pcStep;      // next word address
                        if (haltDecoded)
                                halted <= 1'b1;
                end
        end

        pcAdvance: assert property (@(posedge clk) disable iff (!rstN)
                accept |=> pc == $past(pc) + pcStep)
                else $error("pc did not advance by 2 after an accepted word");

endmodule

//--- logic/stageReg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// payload holds its old value while the valid tag is low
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module stageReg #(
        parameter type payload_t = logic
) (
        input  logic     clk,
        input  logic     rstN,
        input  logic     inValid,
        input  payload_t inData,
        output logic     outValid,
        output payload_t outData
);
        always_ff @(posedge clk) begin
                if (!rstN)
                        outValid <= 1'b0;
                else
                        outValid <= inValid;    // one item per valid cycle
        end

        always_ff @(posedge clk) begin
                if (!rstN)
                        outData <= '0;          // flags and pc clear on reset
                else if (inValid)
                        outData <= inData;      // capture only real items
        end

        validKnown: assert property (@(posedge clk) disable iff (!rstN)
                !$isunknown(outValid))
                else $error("stage valid went unknown");

endmodule

//--- logic/controlDecode.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// unused fields decode to 0, siic only flags illegalOp, rti is a nop
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "decode_settings.svh"

module controlDecode (
        input  logic [`INST_WIDTH-1:0] inst,
        output isaPkg::opcode_e        aluOp,
        output isaPkg::aluFunc_t       aluFunc,
        output isaPkg::regDst_e        regDst,
        output isaPkg::immSize_e       immSize,
        output logic                   jump,
        output logic                   branch,
        output logic                   memRead,
        output logic                   memWrite,
        output logic                   memToReg,
        output logic                   aluSrc,
        output logic                   regWrite,
        output logic                   zeroEx,
        output logic                   halt,
        output logic                   dump,
        output logic                   illegalOp
);
        assign aluOp = isaPkg::opcode_e'(inst[`OPC_MSB:`OPC_LSB]);

        always_comb begin
                aluFunc   = '0;                         // r-format only
                regDst    = isaPkg::REG_DST_I1;
                immSize   = isaPkg::IMM_5;
                jump      = 1'b0;
                branch    = 1'b0;
                memRead   = 1'b0;
                memWrite  = 1'b0;
                memToReg  = 1'b0;
                aluSrc    = 1'b0;
                regWrite  = 1'b0;
                zeroEx    = 1'b0;
                halt      = 1'b0;
                dump      = 1'b0;
                illegalOp = 1'b0;
                case (aluOp)
                        isaPkg::HALT: begin
                                halt = 1'b1;            // freezes fetch
                                dump = 1'b1;            // memory dump request
                        end
                        isaPkg::NOP, isaPkg::RTI: ;     // no epc, nothing to do
                        isaPkg::SIIC: illegalOp = 1'b1; // no trap taken
                        isaPkg::ADDI, isaPkg::SUBI, isaPkg::ROLI,
                        isaPkg::SLLI, isaPkg::RORI, isaPkg::SRLI: begin
                                aluSrc   = 1'b1;        // imm operand
                                regWrite = 1'b1;
                        end
                        isaPkg::XORI, isaPkg::ANDNI: begin
                                aluSrc   = 1'b1;
                                regWrite = 1'b1;
                                zeroEx   = 1'b1;        // logical imm
                        end
                        isaPkg::ST: begin
                                memWrite = 1'b1;
                                aluSrc   = 1'b1;        // base plus offset
                        end
                        isaPkg::LD: begin
                                memRead  = 1'b1;
                                memToReg = 1'b1;
                                aluSrc   = 1'b1;
                                regWrite = 1'b1;
                        end
                        isaPkg::STU: begin
                                regDst   = isaPkg::REG_DST_I2;  // base reg updated
                                memWrite = 1'b1;
                                aluSrc   = 1'b1;
                                regWrite = 1'b1;        // alu result, not mem
                        end
                        isaPkg::ADD_ANDN: begin
                                regDst   = isaPkg::REG_DST_R;
                                aluFunc  = inst[1:0];
                                regWrite = 1'b1;
                                zeroEx   = &inst[1:0];  // andn only
                        end
                        isaPkg::ROL_SRL: begin
                                regDst   = isaPkg::REG_DST_R;
                                aluFunc  = inst[1:0];
                                regWrite = 1'b1;
                        end
                        isaPkg::BTR, isaPkg::SEQ, isaPkg::SLT, isaPkg::SLE, isaPkg::SCO: begin
                                regDst   = isaPkg::REG_DST_R;
                                regWrite = 1'b1;
                        end
                        isaPkg::BEQZ, isaPkg::BNEZ, isaPkg::BLTZ, isaPkg::BGEZ: begin
                                immSize = isaPkg::IMM_8;
                                regDst  = isaPkg::REG_DST_I2;   // tested reg
                                branch  = 1'b1;
                        end
                        isaPkg::LBI, isaPkg::SLBI: begin
                                immSize  = isaPkg::IMM_8;
                                regDst   = isaPkg::REG_DST_I2;
                                regWrite = 1'b1;
                                aluSrc   = (aluOp == isaPkg::SLBI);     // shift-or needs imm path
                                zeroEx   = (aluOp == isaPkg::SLBI);
                        end
                        isaPkg::J: begin
                                immSize = isaPkg::IMM_11;
                                jump    = 1'b1;
                        end
                        isaPkg::JR: begin
                                immSize = isaPkg::IMM_8;
                                regDst  = isaPkg::REG_DST_I2;
                                jump    = 1'b1;
                                aluSrc  = 1'b1;         // reg plus imm
                        end
                        isaPkg::JAL, isaPkg::JALR: begin
                                immSize  = (aluOp == isaPkg::JAL) ? isaPkg::IMM_11 : isaPkg::IMM_8;
                                regDst   = isaPkg::REG_DST_LINK;
                                jump     = 1'b1;
                                aluSrc   = (aluOp == isaPkg::JALR);
                                regWrite = 1'b1;        // return address to r7
                        end
                endcase
        end

endmodule

//--- logic/operandDecode.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register fields sit at fixed bit positions of the 16-bit word
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "decode_settings.svh"

module operandDecode (
        input  logic [`INST_WIDTH-1:0]    inst,
        input  isaPkg::regDst_e           regDst,
        input  isaPkg::immSize_e          immSize,
        input  logic                      zeroEx,
        output logic [`REG_IDX_WIDTH-1:0] writeReg,
        output logic [`INST_WIDTH-1:0]    immediate
);
        logic keepSign;                 // sign fill unless zero-extending

        assign keepSign = ~zeroEx;

        always_comb begin
                case (regDst)
                        isaPkg::REG_DST_R:    writeReg = inst[4:2];
                        isaPkg::REG_DST_I2:   writeReg = inst[10:8];
                        isaPkg::REG_DST_LINK: writeReg = `LINK_REG;
                        default:              writeReg = inst[7:5];     // i-format 1
                endcase
        end

        always_comb begin
                case (immSize)
                        isaPkg::IMM_8:
                                immediate = {{(`INST_WIDTH-8){inst[7] & keepSign}}, inst[7:0]};
                        isaPkg::IMM_11:
                                immediate = {{(`INST_WIDTH-11){inst[10] & keepSign}}, inst[10:0]};
                        default:                                        // 5-bit field
                                immediate = {{(`INST_WIDTH-5){inst[4] & keepSign}}, inst[4:0]};
                endcase
        end

endmodule

//--- logic/decodeTop.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// result leaves 2 cycles after its strobe, strobes after halt are lost
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "decode_settings.svh"

module decodeTop (
        input  logic                      clk,
        input  logic                      rstN,
        input  logic                      instValid,
        input  logic [`INST_WIDTH-1:0]    inst,
        output logic                      outValid,
        output isaPkg::opcode_e           aluOp,
        output isaPkg::aluFunc_t          aluFunc,
        output isaPkg::regDst_e           regDst,
        output logic                      jump,
        output logic                      branch,
        output logic                      memRead,
        output logic                      memWrite,
        output logic                      memToReg,
        output logic                      aluSrc,
        output logic                      regWrite,
        output logic                      zeroEx,
        output logic                      halt,
        output logic                      dump,
        output logic                      illegalOp,
        output logic [`REG_IDX_WIDTH-1:0] writeReg,
        output logic [`INST_WIDTH-1:0]    immediate,
        output logic [`PC_WIDTH-1:0]      pc
);
        typedef struct packed {
                logic [`INST_WIDTH-1:0] inst;
                logic [`PC_WIDTH-1:0]   pc;
        } ifIdPair_t;

        wire ifIdPair_t           fetchPair;    // word plus its pc
        ifIdPair_t                ifIdData;
        wire isaPkg::ctrlBundle_t decoded;      // filled field by field
        isaPkg::ctrlBundle_t      exData;
        isaPkg::immSize_e         immSize;
        logic                     fetchValid;
        logic                     ifIdValid;
        logic                     haltDecoded;

        assign haltDecoded = ifIdValid && decoded.halt;         // stale data ignored
        assign decoded.pc  = ifIdData.pc;

        instFetch u_fetch (
                .clk         (clk),
                .rstN        (rstN),
                .instValid   (instValid),
                .inst        (inst),
                .haltDecoded (haltDecoded),
                .fetchValid  (fetchValid),
                .fetchInst   (fetchPair.inst),
                .fetchPc     (fetchPair.pc)
        );

        stageReg #(.payload_t(ifIdPair_t)) u_ifId (
                .clk      (clk),
                .rstN     (rstN),
                .inValid  (fetchValid),
                .inData   (fetchPair),
                .outValid (ifIdValid),
                .outData  (ifIdData)
        );

        controlDecode u_ctrl (
                .inst      (ifIdData.inst),
                .aluOp     (decoded.aluOp),
                .aluFunc   (decoded.aluFunc),
                .regDst    (decoded.regDst),
                .immSize   (immSize),
                .jump      (decoded.jump),
                .branch    (decoded.branch),
                .memRead   (decoded.memRead),
                .memWrite  (decoded.memWrite),
                .memToReg  (decoded.memToReg),
                .aluSrc    (decoded.aluSrc),
                .regWrite  (decoded.regWrite),
                .zeroEx    (decoded.zeroEx),
                .halt      (decoded.halt),
                .dump      (decoded.dump),
                .illegalOp (decoded.illegalOp)
        );

        operandDecode u_operand (
                .inst      (ifIdData.inst),
                .regDst    (decoded.regDst),
                .immSize   (immSize),
                .zeroEx    (decoded.zeroEx),
                .writeReg  (decoded.writeReg),
                .immediate (decoded.immediate)
        );

        stageReg #(.payload_t(isaPkg::ctrlBundle_t)) u_idEx (
                .clk      (clk),
                .rstN     (rstN),
                .inValid  (ifIdValid),
                .inData   (decoded),
                .outValid (outValid),
                .outData  (exData)
        );

        // id/ex bundle back out as loose ports
        assign aluOp     = exData.aluOp;
        assign aluFunc   = exData.aluFunc;
        assign regDst    = exData.regDst;
        assign jump      = exData.jump;
        assign branch    = exData.branch;
        assign memRead   = exData.memRead;
        assign memWrite  = exData.memWrite;
        assign memToReg  = exData.memToReg;
        assign aluSrc    = exData.aluSrc;
        assign regWrite  = exData.regWrite;
        assign zeroEx    = exData.zeroEx;
        assign halt      = exData.halt;
        assign dump      = exData.dump;
        assign illegalOp = exData.illegalOp;
        assign writeReg  = exData.writeReg;
        assign immediate = exData.immediate;
        assign pc        = exData.pc;

endmodule

//--- verif/decodeRefModel.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// expected decode per opcode class, unused fields held at 0
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef DECODE_REF_MODEL_SVH
`define DECODE_REF_MODEL_SVH

`include "decode_settings.svh"

function automatic isaPkg::ctrlBundle_t decodeFlags(input logic [`INST_WIDTH-1:0] w);
        isaPkg::ctrlBundle_t b;
        isaPkg::opcode_e     op;
        b  = '0;
        op = isaPkg::opcode_e'(w[`OPC_MSB:`OPC_LSB]);
        b.aluOp     = op;
        b.halt      = (op == isaPkg::HALT);
        b.dump      = (op == isaPkg::HALT);             // halt always dumps
        b.illegalOp = (op == isaPkg::SIIC);
        b.jump      = op inside {isaPkg::J, isaPkg::JR, isaPkg::JAL, isaPkg::JALR};
        b.branch    = op inside {isaPkg::BEQZ, isaPkg::BNEZ, isaPkg::BLTZ, isaPkg::BGEZ};
        b.memRead   = (op == isaPkg::LD);
        b.memToReg  = (op == isaPkg::LD);
        b.memWrite  = op inside {isaPkg::ST, isaPkg::STU};
        b.aluSrc    = op inside {isaPkg::ADDI, isaPkg::SUBI, isaPkg::XORI, isaPkg::ANDNI,
                                 isaPkg::ROLI, isaPkg::SLLI, isaPkg::RORI, isaPkg::SRLI,
                                 isaPkg::ST, isaPkg::LD, isaPkg::STU, isaPkg::SLBI,
                                 isaPkg::JR, isaPkg::JALR};
        b.zeroEx    = op inside {isaPkg::XORI, isaPkg::ANDNI, isaPkg::SLBI} ||
                      (op == isaPkg::ADD_ANDN && w[1:0] == 2'b11);      // andn
        // every opcode writes a register except these
        b.regWrite  = !(op inside {isaPkg::HALT, isaPkg::NOP, isaPkg::SIIC, isaPkg::RTI,
                                  isaPkg::J, isaPkg::JR, isaPkg::BEQZ, isaPkg::BNEZ,
                                  isaPkg::BLTZ, isaPkg::BGEZ, isaPkg::ST});
        if (op inside {isaPkg::ROL_SRL, isaPkg::ADD_ANDN})
                b.aluFunc = w[1:0];                     // r-format sub-op
        if (op inside {isaPkg::BTR, isaPkg::ROL_SRL, isaPkg::ADD_ANDN, isaPkg::SEQ,
                       isaPkg::SLT, isaPkg::SLE, isaPkg::SCO})
                b.regDst = isaPkg::REG_DST_R;
        else if (op inside {isaPkg::JAL, isaPkg::JALR})
                b.regDst = isaPkg::REG_DST_LINK;
        else if (op inside {isaPkg::STU, isaPkg::JR, isaPkg::LBI, isaPkg::SLBI} || b.branch)
                b.regDst = isaPkg::REG_DST_I2;
        return b;                                       // else i-format 1
endfunction

function automatic int immWidthFor(input isaPkg::opcode_e op);
        if (op inside {isaPkg::J, isaPkg::JAL})
                return 11;                              // jump displacement
        if (op inside {isaPkg::BEQZ, isaPkg::BNEZ, isaPkg::BLTZ, isaPkg::BGEZ,
                       isaPkg::LBI, isaPkg::SLBI, isaPkg::JR, isaPkg::JALR})
                return 8;
        return 5;
endfunction

function automatic logic [`REG_IDX_WIDTH-1:0] destRegFor(
        input logic [`INST_WIDTH-1:0] w, input isaPkg::regDst_e rd);
        case (rd)
                isaPkg::REG_DST_R:    return w[4:2];
                isaPkg::REG_DST_I2:   return w[10:8];
                isaPkg::REG_DST_LINK: return `REG_IDX_WIDTH'(7);
                default:              return w[7:5];
        endcase
endfunction

function automatic logic [`INST_WIDTH-1:0] extendField(
        input logic [`INST_WIDTH-1:0] w, input int width, input logic zeroEx);
        logic [`INST_WIDTH-1:0] mask;
        mask = (`INST_WIDTH'(1) << width) - `INST_WIDTH'(1);
        if (w[width-1] && !zeroEx)
                return w | ~mask;                       // sign fill
        return w & mask;
endfunction

function automatic isaPkg::ctrlBundle_t expectedBundle(
        input logic [`INST_WIDTH-1:0] w, input logic [`PC_WIDTH-1:0] pcVal);
        isaPkg::ctrlBundle_t b;
        b           = decodeFlags(w);
        b.writeReg  = destRegFor(w, b.regDst);
        b.immediate = extendField(w, immWidthFor(b.aluOp), b.zeroEx);
        b.pc        = pcVal;
        return b;
endfunction

`endif

//--- verif/decodeTb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// random words from seed 50360, halt only where the halt test puts it
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "decode_settings.svh"

module decodeTb;
        timeunit 1ns;
        timeprecision 1ps;

        localparam int sweepReps   = 4;
        localparam int streamWords = 200;
        localparam int maxGap      = 2;
        localparam int cycleBudget = (31 * sweepReps + streamWords + 20) * (maxGap + 1) + 100;

        logic                      clk = 1'b0;
        logic                      rstN;
        logic                      instValid;
        logic [`INST_WIDTH-1:0]    inst;
        logic                      outValid;
        isaPkg::opcode_e           aluOp;
        isaPkg::aluFunc_t          aluFunc;
        isaPkg::regDst_e           regDst;
        logic                      jump;
        logic                      branch;
        logic                      memRead;
        logic                      memWrite;
        logic                      memToReg;
        logic                      aluSrc;
        logic                      regWrite;
        logic                      zeroEx;
        logic                      halt;
        logic                      dump;
        logic                      illegalOp;
        logic [`REG_IDX_WIDTH-1:0] writeReg;
        logic [`INST_WIDTH-1:0]    immediate;
        logic [`PC_WIDTH-1:0]      pc;

        isaPkg::ctrlBundle_t       expQ[$];     // accepted words in order
        int                        cycQ[$];     // strobe cycle of each
        int                        cycCount = 0;
        int                        errors   = 0;
        int                        checked  = 0;
        int                        tests    = 0;
        logic [`PC_WIDTH-1:0]      modelPc;
        logic                      haltSeen;    // later strobes dropped
        isaPkg::ctrlBundle_t       gotB;
        isaPkg::ctrlBundle_t       expB;
        int                        strobeCyc;

        `include "decodeRefModel.svh"

        decodeTop u_dut (.*);

        always #10 clk = ~clk;

        always @(posedge clk) cycCount <= cycCount + 1;

        task automatic checkCtrl(input isaPkg::ctrlBundle_t got, input isaPkg::ctrlBundle_t exp);
                isaPkg::ctrlBundle_t g;
                isaPkg::ctrlBundle_t e;
                g = got;
                e = exp;
                {g.writeReg, g.immediate, g.pc} = '0;   // own checks below
                {e.writeReg, e.immediate, e.pc} = '0;
                if (g !== e) begin
                        errors++;
                        $display("FAILED t=%0t control of word at pc %h: got %h expected %h",
                                 $time, exp.pc, g, e);
                end
        endtask

        task automatic checkReg(input logic [`REG_IDX_WIDTH-1:0] got, exp);
                if (got !== exp) begin
                        errors++;
                        $display("FAILED t=%0t writeReg: got %0d expected %0d", $time, got, exp);
                end
        endtask

        task automatic checkImm(input logic [`INST_WIDTH-1:0] got, exp);
                if (got !== exp) begin
                        errors++;
                        $display("FAILED t=%0t immediate: got %h expected %h", $time, got, exp);
                end
        endtask

        task automatic checkPc(input logic [`PC_WIDTH-1:0] got, exp);
                if (got !== exp) begin
                        errors++;
                        $display("FAILED t=%0t pc: got %h expected %h", $time, got, exp);
                end
        endtask

        task automatic checkLatency(input int got);
                if (got != 2) begin
                        errors++;
                        $display("FAILED t=%0t latency: got %0d cycles expected 2", $time, got);
                end
        endtask

        // outputs sampled mid-cycle, well away from the edge
        always @(negedge clk) begin
                if (rstN && outValid) begin
                        if (expQ.size() == 0) begin
                                errors++;
                                $display("output at %0t has no accepted strobe to match it",
                                         $time);
                        end else begin
                                expB      = expQ.pop_front();
                                strobeCyc = cycQ.pop_front();
                                gotB      = '{aluOp, aluFunc, regDst, jump, branch, memRead,
                                              memWrite, memToReg, aluSrc, regWrite, zeroEx,
                                              halt, dump, illegalOp, writeReg, immediate, pc};
                                checkCtrl(gotB, expB);
                                checkReg(writeReg, expB.writeReg);
                                checkImm(immediate, expB.immediate);
                                checkPc(pc, expB.pc);
                                checkLatency(cycCount - strobeCyc);
                                checked++;
                        end
                end
        end

        task automatic applyReset();
                rstN      = 1'b0;
                instValid = 1'b0;
                expQ.delete();
                cycQ.delete();
                modelPc   = '0;
                haltSeen  = 1'b0;
                repeat (2) @(posedge clk);
                #2 rstN = 1'b1;                         // 2 ns after the edge
        endtask

        // one strobe, then gap idle cycles
        task automatic sendWord(input logic [`INST_WIDTH-1:0] w, input int gap);
                instValid = 1'b1;
                inst      = w;
                if (!haltSeen) begin
                        expQ.push_back(expectedBundle(w, modelPc));
                        cycQ.push_back(cycCount);
                        modelPc  = modelPc + `PC_WIDTH'(2);
                        haltSeen = (isaPkg::opcode_e'(w[`OPC_MSB:`OPC_LSB]) == isaPkg::HALT);
                end
                @(posedge clk);
                #2 instValid = 1'b0;
                repeat (gap) begin
                        @(posedge clk);
                        #2;
                end
        endtask

        function automatic logic [`INST_WIDTH-1:0] randWord();
                logic [`INST_WIDTH-1:0] w;
                w = `INST_WIDTH'($urandom);
                if (w[`OPC_MSB:`OPC_LSB] == '0)
                        w[`OPC_MSB:`OPC_LSB] = isaPkg::NOP;     // keep fetch running
                return w;
        endfunction

        task automatic drainOutputs();
                while (expQ.size() != 0) begin
                        @(posedge clk);
                        #2;
                end
                repeat (4) begin                        // room for stray outputs
                        @(posedge clk);
                        #2;
                end
        endtask

        task automatic reportTest(input string name, input int errMark);
                tests++;
                if (errors == errMark)
                        $display("test %s: ok, %0d words checked so far", name, checked);
                else
                        $display("test %s: %0d errors", name, errors - errMark);
        endtask

        initial begin : stimulus
                logic [`INST_WIDTH-1:0] w;
                int                     errMark;
                void'($urandom(50360));
                rstN      = 1'b0;
                instValid = 1'b0;
                inst      = '0;

                applyReset();
                errMark = errors;
                for (int op = 1; op < 32; op++) begin
                        for (int r = 0; r < sweepReps; r++) begin
                                w = `INST_WIDTH'($urandom);
                                w[`OPC_MSB:`OPC_LSB] = 5'(op);  // random low bits
                                sendWord(w, $urandom_range(maxGap, 0));
                        end
                end
                drainOutputs();
                reportTest("opcode sweep", errMark);

                applyReset();
                errMark = errors;
                for (int i = 0; i < streamWords; i++)
                        sendWord(randWord(), $urandom_range(maxGap, 0));
                drainOutputs();
                reportTest("random stream with gaps", errMark);

                applyReset();
                errMark = errors;
                for (int i = 0; i < 6; i++)
                        sendWord(randWord(), $urandom_range(maxGap, 0));
                w = randWord();
                w[`OPC_MSB:`OPC_LSB] = isaPkg::HALT;
                sendWord(w, 0);                         // next strobe right behind
                for (int i = 0; i < 8; i++)
                        sendWord(randWord(), $urandom_range(maxGap, 0));
                drainOutputs();
                applyReset();                           // pc back to 0
                for (int i = 0; i < 4; i++)
                        sendWord(randWord(), $urandom_range(maxGap, 0));
                drainOutputs();
                reportTest("halt and restart", errMark);

                $display("%0d tests, %0d words checked, %0d errors", tests, checked, errors);
                if (errors == 0)
                        $display("** PASS **");
                else
                        $display("** FAIL **");
                $finish;
        end

        initial begin : watchdog
                #(cycleBudget * 20);
                $display("timeout: the run did not finish within %0d cycles", cycleBudget);
                $display("** FAIL **");
                $finish;
        end

endmodule

//--- decodeStage.f
+incdir+logic
+incdir+verif
logic/isaPkg.sv
logic/instFetch.sv
logic/stageReg.sv
logic/controlDecode.sv
logic/operandDecode.sv
logic/decodeTop.sv
verif/decodeTb.sv

//--- Makefile
# Verilator build and run of the decode stage testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build decodeTb with Verilator, run it and look for the pass line"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f decodeStage.f --top-module decodeTb -Mdir obj_dir
	@out="$$(./obj_dir/VdecodeTb)"; \
		echo "$$out"; \
		echo "$$out" | grep -q '^\*\* PASS \*\*$$'

clean:
	rm -rf obj_dir
